// ==== useq_top.f ====
source/useq_pkg.sv
source/useq_stage_if.sv
source/useq_fetch.sv
source/useq_decode.sv
source/useq_execute.sv
source/useq_irq.sv
source/useq_fifo.sv
source/useq_top.sv
dv/tb_clkgen.sv
dv/tb_useq_top.sv

// ==== dv/tb_useq_top.sv ====
`timescale 1ns/10ps

module tb_useq_top;

	logic            clk;
	logic            rst_n;
	useq_pkg::byte_t mem_data;
	useq_pkg::byte_t i_port;
	useq_pkg::byte_t mem_addr;
	useq_pkg::byte_t o_port;
	logic            out_strobe;

	useq_pkg::byte_t mem [256];             // program and table memory
	useq_pkg::byte_t got_q [$];             // o_port after each strobe
	useq_pkg::byte_t exp_q [$];             // OUT values from the model
	logic            strobe_seen = 1'b0;
	logic [31:0]     lfsr = 32'hc51f;       // random state
	int              wp;                    // program write pointer

	useq_pkg::byte_t m_a;                   // model accumulator
	useq_pkg::byte_t m_r [16];              // model registers
	useq_pkg::byte_t m_fifo [$];            // model fifo
	useq_pkg::byte_t port_val;              // i_port seen by the model

	tb_clkgen i_clkgen (.clk(clk));

	useq_top i_useq_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_data   (mem_data),
		.i_port     (i_port),
		.mem_addr   (mem_addr),
		.o_port     (o_port),
		.out_strobe (out_strobe)
	);

	assign mem_data = mem[mem_addr]; // combinational read

	// o_port is registered at the end of the strobe cycle
	always @(negedge clk) begin
		if (strobe_seen)
			got_q.push_back(o_port);
		strobe_seen = (out_strobe === 1'b1);
	end

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input useq_pkg::byte_t exp,
		input useq_pkg::byte_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, got %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %s: expected %0h, got %0h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		stop_run();
	endtask

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [3:0] rand_nib();
		logic [31:0] r;
		r = rand_bits(4);
		return r[3:0];
	endfunction

	function automatic useq_pkg::byte_t rand_byte();
		logic [31:0] r;
		r = rand_bits(8);
		return r[7:0];
	endfunction

	function automatic void emit(input useq_pkg::byte_t b);
		mem[wp] = b;
		wp++;
	endfunction

	function automatic void load_a(input useq_pkg::byte_t v);
		emit({4'h1, v[3:0]}); // LDL
		emit({4'h2, v[7:4]}); // LDH
	endfunction

	// self-loop through R15 ends every program
	function automatic void halt_here();
		int at;
		at = wp + 3;
		load_a(at[7:0]);
		emit(8'h3f);
		emit(8'h8f);
	endfunction

	function automatic void push_random();
		load_a(rand_byte());
		emit(8'ha2);
	endfunction

	function automatic void pop_and_out();
		emit(8'ha3);
		emit(8'ha0);
	endfunction

	// instruction-set model that runs until the program jumps to itself
	function automatic void run_model();
		useq_pkg::byte_t op;
		useq_pkg::byte_t pc;
		useq_pkg::byte_t nxt;
		logic [3:0]      n;
		int              steps;
		logic            done;
		m_a = '0;
		foreach (m_r[i])
			m_r[i] = '0;
		m_fifo.delete();
		exp_q.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 2000) begin
			op = mem[pc];
			n = op[3:0];
			nxt = pc + 8'd1;
			case (op[7:4])
				4'h1: m_a = {4'h0, n};
				4'h2: m_a[7:4] = n;
				4'h3: m_r[n] = m_a;
				4'h4: m_a = m_r[n];
				4'h5: m_a = m_a + m_r[n];
				4'h6: m_a = m_a - m_r[n];
				4'h7: m_a = m_a & m_r[n];
				4'h8: nxt = m_r[n];
				4'h9: nxt = (m_a != 0) ? m_r[n] : nxt;
				4'ha: begin
					case (n)
						4'h0: exp_q.push_back(m_a);
						4'h1: m_a = port_val;
						4'h2: if (m_fifo.size() < 4) m_fifo.push_back(m_a);
						4'h3: m_a = (m_fifo.size() > 0) ? m_fifo.pop_front() : 8'h00;
						4'hc: begin
							m_r[14] = m_a + 8'd1; // pointer plus one from the old A
							m_a = mem[m_a];
						end
						default: ;
					endcase
				end
				default: ;
			endcase
			done = (nxt == pc);
			pc = nxt;
			steps++;
		end
	endfunction

	task automatic hold_reset();
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = 8'h00; // nop
		wp = 0;
		port_val = '0;
		i_port = '0;
	endtask

	task automatic release_reset();
		repeat (5) @(posedge clk); // 5 cycles low
		#2;
		rst_n = 1'b1;
		got_q.delete();
	endtask

	task automatic wait_outs(input int n, input string what);
		int cyc;
		cyc = 0;
		while (got_q.size() < n && cyc < 3000) begin
			@(posedge clk);
			cyc++;
		end
		if (got_q.size() < n)
			timed_out(what);
	endtask

	task automatic wait_isr_entry();
		int cyc;
		cyc = 0;
		@(negedge clk);
		while (mem_addr !== 8'hf0 && cyc < 200) begin
			@(negedge clk);
			cyc++;
		end
		if (mem_addr !== 8'hf0)
			timed_out("the first fetch from the interrupt vector");
	endtask

	task automatic compare_outs(input string what);
		wait_outs(exp_q.size(), what);
		for (int i = 0; i < exp_q.size(); i++)
			check_byte("o_port", exp_q[i], got_q[i]);
		repeat (20) @(posedge clk); // nothing more may appear
		check_count("out_strobe count", exp_q.size(), got_q.size());
	endtask

	task automatic reset_state();
		hold_reset();
		release_reset();
		@(negedge clk);
		check_byte("o_port", 8'h00, o_port);
		repeat (20) @(posedge clk);
		check_count("out_strobe count", 0, got_q.size());
	endtask

	task automatic random_arith();
		int         k;
		logic [3:0] n;
		hold_reset();
		port_val = rand_byte();
		i_port = port_val; // held for the whole program
		for (int i = 0; i < 48; i++) begin
			k = rand_bits(4) % 9;
			n = rand_nib();
			case (k)
				0: emit({4'h1, n});
				1: emit({4'h2, n});
				2: emit({4'h3, n});
				3: emit({4'h4, n});
				4: emit({4'h5, n});
				5: emit({4'h6, n});
				6: emit({4'h7, n});
				7: emit(8'ha1);
				default: emit(8'ha0);
			endcase
		end
		halt_here();
		run_model();
		release_reset();
		compare_outs("outputs of a random arithmetic program");
	endtask

	// kind picks jmp (0 or 1), jnz taken (2) or jnz not taken (3)
	task automatic jump_flush();
		logic [31:0]     r;
		logic [1:0]      kind;
		logic [3:0]      k;
		logic [3:0]      v;
		int              fill;
		int              at;
		useq_pkg::byte_t tgt;
		hold_reset();
		for (int b = 0; b < 10; b++) begin
			r = rand_bits(2);
			kind = r[1:0];
			k = rand_nib();
			fill = (kind == 2'd3) ? 0 : 1 + int'(rand_bits(2)); // bytes skipped
			at = wp + 6 + fill;
			tgt = (kind == 2'd3) ? rand_byte() : at[7:0];
			v = (kind == 2'd3) ? 4'h0 : (kind == 2'd2) ? (rand_nib() | 4'h1) : rand_nib();
			load_a(tgt);
			emit({4'h3, k});
			emit({4'h1, v});
			emit(8'ha0);
			emit({(kind[1] ? 4'h9 : 4'h8), k});
			for (int f = 0; f < fill; f++)
				emit(rand_byte()); // never executed
		end
		halt_here();
		run_model();
		release_reset();
		compare_outs("outputs of a jump program");
	endtask

	task automatic fifo_order();
		hold_reset();
		for (int i = 0; i < 5; i++)
			push_random(); // last one hits a full fifo
		for (int i = 0; i < 6; i++)
			pop_and_out(); // last one reads empty
		for (int i = 0; i < 16; i++) begin
			if (rand_bits(1) != 0)
				push_random();
			else
				pop_and_out();
		end
		halt_here();
		run_model();
		release_reset();
		compare_outs("outputs of a fifo program");
	endtask

	task automatic lda_table();
		useq_pkg::byte_t t;
		hold_reset();
		for (int i = 0; i < 8; i++) begin
			t = rand_byte();
			t[7:6] = 2'b10; // table above the program
			mem[t] = rand_byte();
			load_a(t);
			emit(8'hac);
			emit(8'ha0);
			emit(8'h4e); // R14 holds address plus one
			emit(8'ha0);
		end
		halt_here();
		run_model();
		release_reset();
		compare_outs("outputs of an lda program");
	endtask

	task automatic irq_entry();
		int              n55;
		useq_pkg::byte_t cnt;
		hold_reset();
		emit(8'h11);  // mask 01
		emit(8'h31);  // R1 = 1
		emit(8'ha4);  // ei
		emit(8'h16);
		emit(8'h32);  // R2 = loop address 6
		emit(8'h10);  // counter 0
		emit(8'ha0);  // out at the loop head
		emit(8'h51);
		emit(8'h82);
		wp = 8'hf0;
		emit(8'h3d);  // save A in R13
		emit(8'h15);
		emit(8'h25);
		emit(8'ha0);  // out 55
		emit(8'h4d);
		emit(8'ha5);  // rti
		release_reset();
		wait_outs(5, "counter outputs before the interrupt");
		@(posedge clk);
		#2;
		i_port = 8'h01;
		wait_isr_entry();
		@(posedge clk);
		#2;
		i_port = 8'h00;
		@(posedge clk);
		#2;
		i_port = 8'h01; // second edge while interrupts are off
		wait_outs(24, "counter outputs after the interrupt");
		n55 = 0;
		cnt = 8'h00;
		foreach (got_q[i]) begin
			if (got_q[i] == 8'h55) begin
				n55++;
			end else begin
				check_byte("o_port", cnt, got_q[i]); // no gap and no repeat
				cnt++;
			end
		end
		check_count("isr output count", 1, n55);
	endtask

	initial begin
		rst_n = 1'b0;
		i_port = '0;
		reset_state();
		repeat (3) random_arith();
		repeat (2) jump_flush();
		fifo_order();
		lda_table();
		irq_entry();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk; // 40 ns period
		end
	end

endmodule

// ==== source/useq_top.sv ====
`timescale 1ns/10ps

module useq_top (
	input  logic              clk,
	input  logic              rst_n,
	input  useq_pkg::byte_t   mem_data,   // program memory, combinational
	input  useq_pkg::byte_t   i_port,
	output useq_pkg::byte_t   mem_addr,
	output useq_pkg::byte_t   o_port,
	output logic              out_strobe
);

	useq_pkg::byte_t fetch_addr;
	useq_pkg::byte_t lda_addr;
	useq_pkg::byte_t redirect_pc;
	useq_pkg::byte_t push_data;
	useq_pkg::byte_t pop_data;
	useq_pkg::byte_t ret_pc;
	useq_pkg::byte_t ei_mask;
	logic            stall;
	logic            redirect;
	logic            flush;
	logic            push;
	logic            pop;
	logic            full;
	logic            empty;
	logic            irq_pending;
	logic            take_irq;
	logic            ei;
	logic            rti;

	useq_stage_if f2d ();  // fetch to decode
	useq_stage_if d2e ();  // decode to execute

	assign mem_addr = stall ? lda_addr : fetch_addr; // LDA borrows the port

	useq_fetch i_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_data    (mem_data),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.flush       (flush),
		.fetch_addr  (fetch_addr),
		.to_dec      (f2d.send)
	);

	useq_decode i_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.flush      (flush),
		.from_fetch (f2d.recv),
		.to_exec    (d2e.send)
	);

	useq_execute i_execute (
		.clk         (clk),
		.rst_n       (rst_n),
		.from_dec    (d2e.recv),
		.mem_data    (mem_data),
		.lda_addr    (lda_addr),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.flush       (flush),
		.push        (push),
		.pop         (pop),
		.push_data   (push_data),
		.pop_data    (pop_data),
		.full        (full),
		.empty       (empty),
		.irq_pending (irq_pending),
		.ret_pc      (ret_pc),
		.take_irq    (take_irq),
		.ei          (ei),
		.ei_mask     (ei_mask),
		.rti         (rti),
		.i_port      (i_port),
		.o_port      (o_port),
		.out_strobe  (out_strobe)
	);

	useq_irq i_irq (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_port      (i_port),
		.ei          (ei),
		.ei_mask     (ei_mask),
		.rti         (rti),
		.take_irq    (take_irq),
		.cur_pc      (d2e.pc),     // pc of the instr being replaced
		.irq_pending (irq_pending),
		.ret_pc      (ret_pc)
	);

	useq_fifo i_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.pop       (pop),
		.push_data (push_data),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty)
	);

endmodule

// ==== source/useq_fifo.sv ====
`timescale 1ns/10ps

module useq_fifo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push,
	input  logic              pop,
	input  useq_pkg::byte_t   push_data,
	output useq_pkg::byte_t   pop_data,
	output logic              full,
	output logic              empty
);

	useq_pkg::byte_t     mem [useq_pkg::fifo_depth]; // circular storage
	useq_pkg::fifo_ptr_t rptr;
	useq_pkg::fifo_ptr_t wptr;
	useq_pkg::fifo_cnt_t count;
	logic                do_push;                     // accepted push
	logic                do_pop;                      // accepted pop

	localparam useq_pkg::fifo_ptr_t last = useq_pkg::fifo_ptr_t'(useq_pkg::fifo_depth - 1);

	assign full     = (count == useq_pkg::fifo_cnt_t'(useq_pkg::fifo_depth));
	assign empty    = (count == '0);
	assign do_push  = push && !full;   // dropped when full
	assign do_pop   = pop && !empty;   // dropped when empty
	assign pop_data = mem[rptr];       // head shown without a read cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr  <= '0;
			wptr  <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wptr <= (wptr == last) ? '0 : wptr + 1'b1;
			if (do_pop)
				rptr <= (rptr == last) ? '0 : rptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wptr] <= push_data;
	end

endmodule

// ==== source/useq_irq.sv ====
`timescale 1ns/10ps

module useq_irq (
	input  logic              clk,
	input  logic              rst_n,
	input  useq_pkg::byte_t   i_port,
	input  logic              ei,          // load mask and enable
	input  useq_pkg::byte_t   ei_mask,
	input  logic              rti,         // re-enable on return
	input  logic              take_irq,    // execute entered the isr
	input  useq_pkg::byte_t   cur_pc,      // pc of replaced instr
	output logic              irq_pending,
	output useq_pkg::byte_t   ret_pc
);

	useq_pkg::byte_t prev_port; // i_port one cycle ago
	useq_pkg::byte_t mask;
	logic            enable;
	logic            rise;      // masked rising edge this cycle

	assign rise = |(i_port & ~prev_port & mask);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prev_port   <= '0;
			mask        <= '0;
			enable      <= 1'b0;   // disabled until EI
			irq_pending <= 1'b0;
			ret_pc      <= '0;
		end else begin
			prev_port <= i_port;
			if (ei)
				mask <= ei_mask;
			if (take_irq) begin
				enable <= 1'b0;       // no nesting
				ret_pc <= cur_pc;
			end else if (ei || rti) begin
				enable <= 1'b1;
			end
			if (take_irq)
				irq_pending <= 1'b0;
			else if (rise && enable)
				irq_pending <= 1'b1;  // edges while disabled are lost
		end
	end

endmodule

// ==== source/useq_execute.sv ====
`timescale 1ns/10ps

module useq_execute (
	input  logic              clk,
	input  logic              rst_n,
	useq_stage_if.recv        from_dec,
	input  useq_pkg::byte_t   mem_data,    // LDA table byte
	output useq_pkg::byte_t   lda_addr,
	output logic              stall,
	output logic              redirect,
	output useq_pkg::byte_t   redirect_pc,
	output logic              flush,
	output logic              push,
	output logic              pop,
	output useq_pkg::byte_t   push_data,
	input  useq_pkg::byte_t   pop_data,
	input  logic              full,
	input  logic              empty,
	input  logic              irq_pending,
	input  useq_pkg::byte_t   ret_pc,
	output logic              take_irq,
	output logic              ei,
	output useq_pkg::byte_t   ei_mask,
	output logic              rti,
	input  useq_pkg::byte_t   i_port,
	output useq_pkg::byte_t   o_port,
	output logic              out_strobe
);

	useq_pkg::byte_t  a_reg;                       // accumulator
	useq_pkg::byte_t  regs [useq_pkg::reg_cnt];    // R0..R15
	logic             lda_phase;                   // second LDA cycle
	useq_pkg::ctrl_t  ctl;
	useq_pkg::byte_t  reg_val;                     // R[n] operand
	useq_pkg::byte_t  a_next;
	logic             live;                        // instr really executes
	logic             jump_taken;

	assign ctl     = from_dec.ctrl;
	assign reg_val = regs[ctl.reg_idx];

	// irq replaces any valid non-jump instr outside the second LDA cycle
	assign take_irq = from_dec.valid && irq_pending && !ctl.is_jump && !lda_phase;
	assign live     = from_dec.valid && !take_irq && !lda_phase;

	assign jump_taken = live && ctl.is_jump &&
		((ctl.op != useq_pkg::op_jnz) || (a_reg != '0)); // jnz needs A nonzero

	assign redirect = take_irq || jump_taken;
	assign flush    = redirect;                      // kill fetch and decode slots

	always_comb begin
		if (take_irq)
			redirect_pc = useq_pkg::isr_vect;
		else if (ctl.op == useq_pkg::op_rti)
			redirect_pc = ret_pc;                     // back to replaced instr
		else
			redirect_pc = reg_val;                    // jmp and jnz target
	end

	assign stall    = live && ctl.needs_mem;  // first LDA cycle borrows memory
	assign lda_addr = a_reg;

	assign push       = live && (ctl.op == useq_pkg::op_push) && !full; // dropped when full
	assign pop        = live && (ctl.op == useq_pkg::op_pop);
	assign push_data  = a_reg;
	assign ei         = live && (ctl.op == useq_pkg::op_ei);
	assign ei_mask    = a_reg;
	assign rti        = live && (ctl.op == useq_pkg::op_rti);
	assign out_strobe = live && (ctl.op == useq_pkg::op_out); // one cycle per OUT

	always_comb begin
		case (ctl.op)
			useq_pkg::op_ldl: a_next = {4'h0, ctl.imm};        // zero-extended
			useq_pkg::op_ldh: a_next = {ctl.imm, a_reg[3:0]};
			useq_pkg::op_ld:  a_next = reg_val;
			useq_pkg::op_add: a_next = a_reg + reg_val;       // wraps mod 256
			useq_pkg::op_sub: a_next = a_reg - reg_val;
			useq_pkg::op_and: a_next = a_reg & reg_val;
			useq_pkg::op_in:  a_next = i_port;
			useq_pkg::op_pop: a_next = empty ? '0 : pop_data; // empty reads 0
			useq_pkg::op_lda: a_next = mem_data;              // addressed by A
			default:          a_next = a_reg;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_reg     <= '0;
			o_port    <= '0;
			lda_phase <= 1'b0;
			for (int i = 0; i < useq_pkg::reg_cnt; i++) begin
				regs[i] <= '0;
			end
		end else begin
			lda_phase <= stall;                        // hold one more cycle then retire
			if (live && ctl.wr_a)
				a_reg <= a_next;
			if (live && ctl.wr_reg)
				regs[ctl.reg_idx] <= ctl.needs_mem ? a_reg + 1'b1 : a_reg; // lda ptr or ST
			if (out_strobe)
				o_port <= a_reg;                         // held until next OUT
		end
	end

endmodule

// ==== source/useq_decode.sv ====
`timescale 1ns/10ps

module useq_decode (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         stall,      // hold slot during LDA
	input  logic         flush,      // kill slot on redirect
	useq_stage_if.recv   from_fetch,
	useq_stage_if.send   to_exec
);

	useq_pkg::ctrl_t ctl; // decoded form of from_fetch.instr

	always_comb begin
		ctl           = '0;
		ctl.op        = useq_pkg::op_nop;           // unknown codes stay nop
		ctl.reg_idx   = from_fetch.instr[3:0];
		ctl.imm       = from_fetch.instr[3:0];
		case (from_fetch.instr[7:4])
			useq_pkg::opc_ldl: begin ctl.op = useq_pkg::op_ldl; ctl.wr_a = 1'b1; end
			useq_pkg::opc_ldh: begin ctl.op = useq_pkg::op_ldh; ctl.wr_a = 1'b1; end
			useq_pkg::opc_st:  begin ctl.op = useq_pkg::op_st;  ctl.wr_reg = 1'b1; end
			useq_pkg::opc_ld:  begin ctl.op = useq_pkg::op_ld;  ctl.wr_a = 1'b1; end
			useq_pkg::opc_add: begin ctl.op = useq_pkg::op_add; ctl.wr_a = 1'b1; end
			useq_pkg::opc_sub: begin ctl.op = useq_pkg::op_sub; ctl.wr_a = 1'b1; end
			useq_pkg::opc_and: begin ctl.op = useq_pkg::op_and; ctl.wr_a = 1'b1; end
			useq_pkg::opc_jmp: begin ctl.op = useq_pkg::op_jmp; ctl.is_jump = 1'b1; end
			useq_pkg::opc_jnz: begin ctl.op = useq_pkg::op_jnz; ctl.is_jump = 1'b1; end
			useq_pkg::opc_sys: begin
				case (from_fetch.instr[3:0])
					useq_pkg::sys_out:  ctl.op = useq_pkg::op_out;
					useq_pkg::sys_in:   begin ctl.op = useq_pkg::op_in;  ctl.wr_a = 1'b1; end
					useq_pkg::sys_push: ctl.op = useq_pkg::op_push;
					useq_pkg::sys_pop:  begin ctl.op = useq_pkg::op_pop; ctl.wr_a = 1'b1; end
					useq_pkg::sys_ei:   ctl.op = useq_pkg::op_ei;
					useq_pkg::sys_rti:  begin ctl.op = useq_pkg::op_rti; ctl.is_jump = 1'b1; end
					useq_pkg::sys_lda: begin
						ctl.op        = useq_pkg::op_lda;
						ctl.wr_a      = 1'b1;              // table byte
						ctl.wr_reg    = 1'b1;              // pointer plus one
						ctl.reg_idx   = useq_pkg::lda_ptr;
						ctl.needs_mem = 1'b1;
					end
					default: ctl.op = useq_pkg::op_nop;
				endcase
			end
			default: ctl.op = useq_pkg::op_nop;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			to_exec.valid <= 1'b0;
		end else if (flush) begin
			to_exec.valid <= 1'b0;          // wrong-path slot
		end else if (!stall) begin
			to_exec.valid <= from_fetch.valid;
		end
	end

	// payload follows the valid flag
	always_ff @(posedge clk) begin
		if (!stall) begin
			to_exec.ctrl  <= ctl;
			to_exec.pc    <= from_fetch.pc;  // return address for irq entry
			to_exec.instr <= from_fetch.instr;
		end
	end

endmodule

// ==== source/useq_fetch.sv ====
`timescale 1ns/10ps

module useq_fetch (
	input  logic              clk,
	input  logic              rst_n,
	input  useq_pkg::byte_t   mem_data,    // opcode at fetch_addr
	input  logic              stall,       // LDA owns the memory port
	input  logic              redirect,    // jump, rti or irq entry
	input  useq_pkg::byte_t   redirect_pc, // new fetch address
	input  logic              flush,       // drop captured instruction
	output useq_pkg::byte_t   fetch_addr,
	useq_stage_if.send        to_dec
);

	useq_pkg::byte_t pc; // next address to fetch

	assign fetch_addr = pc;
	assign to_dec.ctrl = '0; // decode fills this in

	// pc and valid flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc           <= '0;  // start at address 0
			to_dec.valid <= 1'b0;
		end else begin
			if (redirect) begin
				pc <= redirect_pc;  // target fetched from next cycle
			end else if (!stall) begin
				pc <= pc + 1'b1;
			end
			if (redirect || flush) begin
				to_dec.valid <= 1'b0; // younger instr is on the wrong path
			end else if (!stall) begin
				to_dec.valid <= 1'b1;
			end
		end
	end

	// captured opcode and its address
	always_ff @(posedge clk) begin
		if (!stall) begin
			to_dec.instr <= mem_data;
			to_dec.pc    <= pc;
		end
	end

endmodule

// ==== source/useq_stage_if.sv ====
`timescale 1ns/10ps

// one instruction slot between two pipeline stages
interface useq_stage_if;

	logic              valid; // slot holds a live instruction
	useq_pkg::byte_t   pc;    // address it was fetched from
	useq_pkg::byte_t   instr; // raw opcode byte
	useq_pkg::ctrl_t   ctrl;  // decoded control, unused after fetch

	modport send (
		output valid,
		output pc,
		output instr,
		output ctrl
	);

	modport recv (
		input valid,
		input pc,
		input instr,
		input ctrl
	);

endinterface

// ==== source/useq_pkg.sv ====
package useq_pkg;

	localparam int data_w     = 8;            // data and address width
	localparam int reg_cnt    = 16;           // R0 to R15
	localparam int fifo_depth = 4;            // byte fifo entries
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

	localparam logic [data_w-1:0] isr_vect = 8'hf0; // fixed interrupt entry

	// high nibble of the opcode
	localparam logic [3:0] opc_ldl = 4'h1;
	localparam logic [3:0] opc_ldh = 4'h2;
	localparam logic [3:0] opc_st  = 4'h3;
	localparam logic [3:0] opc_ld  = 4'h4;
	localparam logic [3:0] opc_add = 4'h5;
	localparam logic [3:0] opc_sub = 4'h6;
	localparam logic [3:0] opc_and = 4'h7;
	localparam logic [3:0] opc_jmp = 4'h8;
	localparam logic [3:0] opc_jnz = 4'h9;
	localparam logic [3:0] opc_sys = 4'ha;     // low nibble picks the op

	// low nibble inside the sys group
	localparam logic [3:0] sys_out  = 4'h0;
	localparam logic [3:0] sys_in   = 4'h1;
	localparam logic [3:0] sys_push = 4'h2;
	localparam logic [3:0] sys_pop  = 4'h3;
	localparam logic [3:0] sys_ei   = 4'h4;
	localparam logic [3:0] sys_rti  = 4'h5;
	localparam logic [3:0] sys_lda  = 4'hc;

	localparam logic [$clog2(reg_cnt)-1:0] lda_ptr = 4'he; // LDA leaves A+1 in R14

	typedef logic [data_w-1:0]     byte_t;
	typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
	typedef logic [fifo_cnt_w-1:0] fifo_cnt_t;

	typedef enum logic [4:0] {
		op_nop, op_ldl, op_ldh, op_st, op_ld, op_add, op_sub, op_and,
		op_jmp, op_jnz, op_out, op_in, op_push, op_pop, op_ei, op_rti, op_lda
	} op_t;

	typedef struct packed {
		op_t                           op;
		logic [$clog2(reg_cnt)-1:0]    reg_idx;   // register operand
		logic [3:0]                    imm;       // immediate nibble
		logic                          wr_a;      // result goes to A
		logic                          wr_reg;    // result goes to R[reg_idx]
		logic                          is_jump;   // may redirect fetch
		logic                          needs_mem; // borrows the memory port
	} ctrl_t;

endpackage
